// File: trk_pkg.sv
package trk_pkg;

	typedef logic [7:0]  byte_t;        // one packet byte
	typedef logic [5:0]  buf_addr_t;    // packet buffer address
	typedef logic [17:0] mem_addr_t;    // main memory word address
	typedef logic [31:0] mem_word_t;    // main memory word
	typedef logic [4:0]  slot_t;        // blob pointer slot
	typedef logic [4:0]  blob_count_t;  // number of valid blobs
	typedef logic [2:0]  colour_idx_t;  // position in the mode's colour list

	// colour code is the low byte of blob word one minus one
	typedef enum logic [2:0] {
		RED    = 3'd0,
		ORANGE = 3'd1,
		YELLOW = 3'd2,
		GREEN  = 3'd3,
		BLUE   = 3'd4,
		PURPLE = 3'd5
	} colour_t;

	// value doubles as the protocol version byte
	typedef enum logic [1:0] {
		MODE_1 = 2'd1,  // red, green, blue
		MODE_2 = 2'd2   // all six colours
	} track_mode_t;

	localparam byte_t START_MARKER    = 8'd176;
	localparam byte_t LINE_FEED       = 8'd10;
	localparam byte_t CARRIAGE_RETURN = 8'd13;

	localparam mem_addr_t NULL_POINTER = '1;  // empty pointer slot

	// packet layout
	localparam buf_addr_t FIELD_BASE  = 6'd2;   // first byte after the header
	localparam buf_addr_t CLEAR_BYTES = 6'd52;  // largest packet size

endpackage

// File: blob_if.sv
`timescale 1ns/10ps

interface blob_if;
	import trk_pkg::*;

	logic        valid;
	logic        ready;
	colour_idx_t colour_idx;
	logic [1:0]  rank;      // 1 or 2
	byte_t       x;
	byte_t       y;
	byte_t       size_hi;
	byte_t       size_lo;
	track_mode_t mode;      // latched at the start of a run
	logic        active;    // high for the whole run

	modport fetch (
		output valid, colour_idx, rank, x, y, size_hi, size_lo, mode, active,
		input  ready
	);

	modport store (
		input  valid, colour_idx, rank, x, y, size_hi, size_lo, mode, active,
		output ready
	);

endinterface

// File: blob_fetcher.sv
`timescale 1ns/10ps

module blob_fetcher #(
	parameter int POINTER_SLOTS = 20
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pause,
	input  logic                 enable,
	input  logic                 mode_sel,
	input  trk_pkg::mem_addr_t   blob_pointer,
	input  trk_pkg::blob_count_t number_of_valid_blobs,
	input  trk_pkg::mem_word_t   data_read,
	output trk_pkg::slot_t       blob_pointer_addr,
	output trk_pkg::mem_addr_t   address,
	output logic [5:0]           tracking_display,
	output logic [6:0]           number_of_bytes_to_transmit,
	output logic                 done,
	blob_if.fetch                b
);
	import trk_pkg::*;

	typedef enum logic [2:0] {
		F_WAIT_SETUP,
		F_READ_PTR,
		F_READ_WORD1,
		F_READ_WORD2,
		F_OFFER,
		F_NEXT_SLOT,
		F_DONE
	} fetch_state_t;

	fetch_state_t state;
	slot_t        slot_q;
	blob_count_t  stored_count;
	byte_t        colour_code;
	colour_t      colour;
	logic         colour_known;   // code names one of the six colours
	colour_idx_t  list_idx;
	logic         in_list;
	logic         keep;           // current blob goes into the packet

	// colour decode straight off word one
	always_comb begin
		colour_code  = data_read[7:0] - 8'd1;
		colour       = colour_t'(colour_code[2:0]);
		colour_known = (colour_code < 8'd6);
		list_idx     = colour_code[2:0];
		in_list      = colour_known;
		if (b.mode == MODE_1) begin
			case (colour)
				RED:     list_idx = 3'd0;
				GREEN:   list_idx = 3'd1;
				BLUE:    list_idx = 3'd2;
				default: in_list = 1'b0;  // shown but not stored
			endcase
		end
	end

	assign blob_pointer_addr = state == F_DONE ? slot_t'(0) : slot_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state                       <= F_WAIT_SETUP;
			slot_q                      <= '0;
			address                     <= '0;
			tracking_display            <= '0;
			number_of_bytes_to_transmit <= '0;
			done                        <= 1'b0;
			stored_count                <= '0;
			keep                        <= 1'b0;
			b.valid                     <= 1'b0;
			b.active                    <= 1'b0;
			b.mode                      <= MODE_1;
		end else if (!pause) begin
			if (!enable) begin
				state            <= F_WAIT_SETUP;
				slot_q           <= '0;
				address          <= '0;
				tracking_display <= '0;
				done             <= 1'b0;
				stored_count     <= '0;
				b.valid          <= 1'b0;
				b.active         <= 1'b0;
			end else begin
				case (state)
					F_WAIT_SETUP: begin
						if (!b.active) begin  // enable has just risen
							b.active                    <= 1'b1;
							b.mode                      <= mode_sel ? MODE_2 : MODE_1;
							number_of_bytes_to_transmit <= mode_sel ? 7'd52 : 7'd28;  // 4 + 8n
						end else if (b.ready) begin
							state <= F_READ_PTR;  // writer has the header down
						end
					end
					F_READ_PTR: begin
						if (stored_count >= number_of_valid_blobs)
							state <= F_DONE;
						else if (blob_pointer == NULL_POINTER)
							state <= F_NEXT_SLOT;
						else if (slot_q >= slot_t'(12))  // rank 3 ends the run
							state <= F_DONE;
						else begin
							address <= blob_pointer;
							state   <= F_READ_WORD1;
						end
					end
					F_READ_WORD1: begin
						if (colour_known)
							tracking_display[colour_code[2:0]] <= 1'b1;
						keep    <= in_list;
						address <= address + mem_addr_t'(1);
						state   <= F_READ_WORD2;
					end
					F_READ_WORD2: begin
						address <= '0;
						if (keep) begin
							b.valid <= 1'b1;
							state   <= F_OFFER;
						end else begin
							state <= F_NEXT_SLOT;
						end
					end
					F_OFFER: begin
						if (b.ready) begin  // transfer this cycle
							b.valid      <= 1'b0;
							stored_count <= stored_count + blob_count_t'(1);
							state        <= F_NEXT_SLOT;
						end
					end
					F_NEXT_SLOT: begin
						if (slot_q == slot_t'(POINTER_SLOTS - 1)) begin
							state <= F_DONE;
						end else begin
							slot_q <= slot_q + slot_t'(1);
							state  <= F_READ_PTR;
						end
					end
					F_DONE: begin
						address <= '0;
						if (b.ready)
							done <= 1'b1;  // last field writes are finished
					end
					default: state <= F_WAIT_SETUP;
				endcase
			end
		end
	end

	// blob payload, reloaded per slot
	always_ff @(posedge clk) begin
		if (!pause) begin
			if (state == F_READ_PTR)
				b.rank <= (slot_q < slot_t'(6)) ? 2'd1 : 2'd2;
			if (state == F_READ_WORD1)
				b.colour_idx <= list_idx;
			if (state == F_READ_WORD2) begin
				b.x       <= data_read[31:24];
				b.y       <= data_read[23:16];
				b.size_hi <= data_read[15:8];
				b.size_lo <= data_read[7:0];
			end
		end
	end

endmodule

// File: packet_writer.sv
`timescale 1ns/10ps

module packet_writer (
	input  logic               clk,
	input  logic               rst,
	input  logic               pause,
	blob_if.store              b,
	output logic               wr_en,
	output trk_pkg::buf_addr_t wr_addr,
	output trk_pkg::byte_t     wr_data
);
	import trk_pkg::*;

	typedef enum logic [2:0] {
		W_IDLE,
		W_CLEAR,
		W_HEADER,
		W_READY,
		W_FIELDS
	} write_state_t;

	write_state_t state;
	buf_addr_t    cnt;           // clear address or field step
	logic         write_phase;

	// latched blob
	colour_idx_t idx_q;
	logic [1:0]  rank_q;
	byte_t       x_q;
	byte_t       y_q;
	byte_t       hi_q;
	byte_t       lo_q;

	buf_addr_t n_cols;
	buf_addr_t slot_pos;         // r * n + k
	buf_addr_t xy_addr;
	buf_addr_t size_addr;
	buf_addr_t trailer_addr;

	assign n_cols       = (b.mode == MODE_1) ? buf_addr_t'(3) : buf_addr_t'(6);
	assign slot_pos     = ((rank_q == 2'd2) ? n_cols : buf_addr_t'(0)) + buf_addr_t'(idx_q);
	assign xy_addr      = FIELD_BASE + (slot_pos << 1);
	assign size_addr    = FIELD_BASE + (n_cols << 2) + (slot_pos << 1);
	assign trailer_addr = FIELD_BASE + (n_cols << 3);

	assign b.ready = (state == W_READY);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= W_IDLE;
			cnt   <= '0;
		end else if (!pause) begin
			if (!b.active) begin
				state <= W_IDLE;
				cnt   <= '0;
			end else begin
				case (state)
					W_IDLE: begin
						cnt   <= '0;
						state <= W_CLEAR;
					end
					W_CLEAR: begin
						if (cnt == CLEAR_BYTES - 6'd1) begin
							cnt   <= '0;
							state <= W_HEADER;
						end else begin
							cnt <= cnt + 6'd1;
						end
					end
					W_HEADER, W_FIELDS: begin
						if (cnt == 6'd3) begin
							cnt   <= '0;
							state <= W_READY;
						end else begin
							cnt <= cnt + 6'd1;
						end
					end
					W_READY: begin
						if (b.valid) begin
							cnt   <= '0;
							state <= W_FIELDS;
						end
					end
					default: state <= W_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!pause && state == W_READY && b.valid) begin
			idx_q  <= b.colour_idx;
			rank_q <= b.rank;
			x_q    <= b.x;
			y_q    <= b.y;
			hi_q   <= b.size_hi;
			lo_q   <= b.size_lo;
		end
	end

	// address and data in the same cycle
	always_comb begin
		write_phase = 1'b0;
		wr_addr     = cnt;
		wr_data     = '0;
		case (state)
			W_CLEAR: write_phase = 1'b1;
			W_HEADER: begin
				write_phase = 1'b1;
				case (cnt[1:0])
					2'd0: begin
						wr_addr = 6'd0;
						wr_data = START_MARKER;
					end
					2'd1: begin
						wr_addr = 6'd1;
						wr_data = byte_t'(b.mode);  // protocol version
					end
					2'd2: begin
						wr_addr = trailer_addr;
						wr_data = LINE_FEED;
					end
					default: begin
						wr_addr = trailer_addr + 6'd1;
						wr_data = CARRIAGE_RETURN;
					end
				endcase
			end
			W_FIELDS: begin
				write_phase = 1'b1;
				case (cnt[1:0])
					2'd0: begin
						wr_addr = xy_addr;
						wr_data = x_q;
					end
					2'd1: begin
						wr_addr = xy_addr + 6'd1;
						wr_data = y_q;
					end
					2'd2: begin
						wr_addr = size_addr;
						wr_data = hi_q;
					end
					default: begin
						wr_addr = size_addr + 6'd1;
						wr_data = lo_q;
					end
				endcase
			end
			default: write_phase = 1'b0;
		endcase
	end

	assign wr_en = write_phase & ~pause;  // buffer frozen during pause

endmodule

// File: packet_buffer.sv
`timescale 1ns/10ps

module packet_buffer #(
	parameter int BUF_DEPTH = 64
) (
	input  logic               clk,
	input  logic               wr_en,
	input  trk_pkg::buf_addr_t wr_addr,
	input  trk_pkg::byte_t     wr_data,
	input  trk_pkg::buf_addr_t read_addr,
	output trk_pkg::byte_t     read_data
);
	import trk_pkg::*;

	byte_t mem [BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// transmit side, one cycle latency
	always_ff @(posedge clk) begin
		read_data <= mem[read_addr];
	end

endmodule

// File: tracking_output_assembly.sv
`timescale 1ns/10ps

module tracking_output_assembly #(
	parameter int POINTER_SLOTS = 20,
	parameter int BUF_DEPTH     = 64
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pause,
	input  logic                 enable,
	input  trk_pkg::byte_t       slide_switches,
	input  trk_pkg::mem_addr_t   blob_pointer,
	input  trk_pkg::blob_count_t number_of_valid_blobs,
	input  trk_pkg::mem_word_t   data_read,
	input  trk_pkg::buf_addr_t   read_addr,
	output trk_pkg::slot_t       blob_pointer_addr,
	output trk_pkg::mem_addr_t   address,
	output trk_pkg::byte_t       read_data,
	output logic [6:0]           number_of_bytes_to_transmit,
	output logic [5:0]           tracking_display,
	output logic                 done
);
	import trk_pkg::*;

	logic      wr_en;
	buf_addr_t wr_addr;
	byte_t     wr_data;

	blob_if blob_bus ();

	blob_fetcher #(
		.POINTER_SLOTS(POINTER_SLOTS)
	) u_fetcher (
		.clk                        (clk),
		.rst                        (rst),
		.pause                      (pause),
		.enable                     (enable),
		.mode_sel                   (slide_switches[1]),  // 01 mode 1, 10 and 11 mode 2
		.blob_pointer               (blob_pointer),
		.number_of_valid_blobs      (number_of_valid_blobs),
		.data_read                  (data_read),
		.blob_pointer_addr          (blob_pointer_addr),
		.address                    (address),
		.tracking_display           (tracking_display),
		.number_of_bytes_to_transmit(number_of_bytes_to_transmit),
		.done                       (done),
		.b                          (blob_bus)
	);

	packet_writer u_writer (
		.clk    (clk),
		.rst    (rst),
		.pause  (pause),
		.b      (blob_bus),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	packet_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_buffer (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.read_addr(read_addr),
		.read_data(read_data)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset drops on a falling edge like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: tb_tracking_output.sv
`timescale 1ns/10ps

module tb_tracking_output;
	import trk_pkg::*;

	localparam int        SLOTS       = 20;
	localparam int        RUN_LIMIT   = 5000;  // cycles allowed for one run
	localparam int        IDLE_LIMIT  = 20;
	localparam int        FETCH_START = 58;    // setup, clear and header come first
	localparam mem_addr_t EMPTY_PTR   = 18'h3ffff;

	logic        clk;
	logic        rst;
	logic        pause;
	logic        enable;
	byte_t       slide_switches;
	mem_addr_t   blob_pointer = '0;
	blob_count_t number_of_valid_blobs;
	mem_word_t   data_read = '0;
	buf_addr_t   read_addr;
	slot_t       blob_pointer_addr;
	mem_addr_t   address;
	byte_t       read_data;
	logic [6:0]  number_of_bytes_to_transmit;
	logic [5:0]  tracking_display;
	logic        done;

	mem_addr_t   ptr_mem [SLOTS];
	mem_word_t   word1_mem [SLOTS];
	mem_word_t   word2_mem [SLOTS];
	byte_t       exp_bytes [52];
	logic [31:0] lfsr;
	int          test_count;

	tb_clock_gen clock_gen (
		.clk(clk),
		.rst(rst)
	);

	tracking_output_assembly dut (
		.clk                        (clk),
		.rst                        (rst),
		.pause                      (pause),
		.enable                     (enable),
		.slide_switches             (slide_switches),
		.blob_pointer               (blob_pointer),
		.number_of_valid_blobs      (number_of_valid_blobs),
		.data_read                  (data_read),
		.read_addr                  (read_addr),
		.blob_pointer_addr          (blob_pointer_addr),
		.address                    (address),
		.read_data                  (read_data),
		.number_of_bytes_to_transmit(number_of_bytes_to_transmit),
		.tracking_display           (tracking_display),
		.done                       (done)
	);

	function automatic mem_addr_t pointer_at(slot_t s);
		if (int'(s) < SLOTS)
			return ptr_mem[s];
		return EMPTY_PTR;
	endfunction

	function automatic mem_word_t word_at(mem_addr_t a);
		mem_word_t w;
		w = {a, ~a[13:0]};  // words no blob owns
		for (int i = 0; i < SLOTS; i++) begin
			if (ptr_mem[i] != EMPTY_PTR && ptr_mem[i] == a)
				w = word1_mem[i];
			if (ptr_mem[i] != EMPTY_PTR && ptr_mem[i] + 18'd1 == a)
				w = word2_mem[i];
		end
		return w;
	endfunction

	// both memories answer on the falling edge after the address
	always @(negedge clk) begin
		blob_pointer <= pointer_at(blob_pointer_addr);
		data_read    <= word_at(address);
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int width, output int value);
		value = 0;
		for (int i = 0; i < width; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input int addr, input byte_t got, input byte_t exp);
		if (got !== exp)
			report_failure($sformatf("Fail test %0d read_data[%0d] got 0x%h expected 0x%h",
				test_count, addr, got, exp));
	endtask

	task automatic check_display(input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp)
			report_failure($sformatf("Fail test %0d tracking_display got 0x%h expected 0x%h",
				test_count, got, exp));
	endtask

	task automatic check_count(input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp)
			report_failure($sformatf(
				"Fail test %0d number_of_bytes_to_transmit got 0x%h expected 0x%h",
				test_count, got, exp));
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Fail test %0d done got 0x%h expected 0x%h",
				test_count, got, exp));
	endtask

	task automatic check_mem_addr(input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("Fail test %0d address got 0x%h expected 0x%h",
				test_count, got, exp));
	endtask

	task automatic check_slot(input slot_t got, input slot_t exp);
		if (got !== exp)
			report_failure($sformatf("Fail test %0d blob_pointer_addr got 0x%h expected 0x%h",
				test_count, got, exp));
	endtask

	// reference packet from the layout and run rules
	task automatic build_expected(input logic mode2, input blob_count_t limit,
			output logic [5:0] disp, output logic [6:0] count);
		int    n;
		int    stored;
		int    k;
		int    s;
		byte_t code;
		n      = mode2 ? 6 : 3;
		stored = 0;
		disp   = '0;
		count  = 7'(4 + 8 * n);
		foreach (exp_bytes[i])
			exp_bytes[i] = 8'h00;
		exp_bytes[0]         = 8'd176;
		exp_bytes[1]         = mode2 ? 8'd2 : 8'd1;
		exp_bytes[2 + 8 * n] = 8'd10;
		exp_bytes[3 + 8 * n] = 8'd13;
		for (int slot = 0; slot < SLOTS; slot++) begin
			if (stored >= int'(limit))
				break;
			if (ptr_mem[slot] == EMPTY_PTR)
				continue;
			if (slot >= 12)
				break;  // rank 3 pointer
			code = word1_mem[slot][7:0] - 8'd1;
			if (code < 8'd6)
				disp[code[2:0]] = 1'b1;  // every fetched colour lights up
			k    = -1;
			if (mode2 && code < 8'd6)
				k = int'(code);
			else if (!mode2 && code == 8'd0)
				k = 0;
			else if (!mode2 && code == 8'd3)
				k = 1;
			else if (!mode2 && code == 8'd4)
				k = 2;
			if (k >= 0) begin
				s = ((slot < 6) ? 0 : n) + k;
				exp_bytes[2 + 2 * s]         = word2_mem[slot][31:24];
				exp_bytes[3 + 2 * s]         = word2_mem[slot][23:16];
				exp_bytes[2 + 4 * n + 2 * s] = word2_mem[slot][15:8];
				exp_bytes[3 + 4 * n + 2 * s] = word2_mem[slot][7:0];
				stored++;
			end
		end
	endtask

	task automatic run_test(input byte_t sw, input blob_count_t nvb, input logic use_pause,
			input logic [5:0] file_display, input logic [6:0] file_count);
		int         cycles;
		int         pause_start;
		int         pause_len;
		logic [5:0] exp_display;
		logic [6:0] exp_count;
		mem_addr_t  held_addr;
		slot_t      held_slot;
		logic [5:0] held_display;
		build_expected(sw[1], nvb, exp_display, exp_count);
		if (exp_display !== file_display || exp_count !== file_count)
			report_failure($sformatf("test %0d: tb_tests.txt disagrees with the packet rules",
				test_count));
		draw_bits(4, pause_start);
		draw_bits(5, pause_len);
		pause_start = pause_start + FETCH_START;  // lands while slots are walked
		pause_len   = pause_len + 1;
		@(negedge clk);
		slide_switches        = sw;
		number_of_valid_blobs = nvb;
		enable                = 1'b1;
		cycles                = 0;
		while (done !== 1'b1) begin
			if (cycles == RUN_LIMIT)
				report_failure($sformatf("test %0d: done never came high", test_count));
			held_addr    = address;
			held_slot    = blob_pointer_addr;
			held_display = tracking_display;
			@(negedge clk);
			if (pause) begin  // the edge just passed was frozen
				check_done(done, 1'b0);
				check_mem_addr(address, held_addr);
				check_slot(blob_pointer_addr, held_slot);
				check_display(tracking_display, held_display);
			end
			cycles++;
			pause = use_pause && cycles >= pause_start && cycles < pause_start + pause_len;
		end
		pause = 1'b0;
		check_done(done, 1'b1);
		check_display(tracking_display, exp_display);
		check_count(number_of_bytes_to_transmit, exp_count);
		for (int a = 0; a < 52; a++) begin
			read_addr = buf_addr_t'(a);
			@(negedge clk);
			check_byte(a, read_data, exp_bytes[a]);
		end
		// dropping enable ends the run
		enable = 1'b0;
		cycles = 0;
		while (done !== 1'b0) begin
			if (cycles == IDLE_LIMIT)
				report_failure($sformatf("test %0d: done stayed high after enable fell",
					test_count));
			@(negedge clk);
			cycles++;
		end
		check_display(tracking_display, 6'h00);
		check_mem_addr(address, 18'h0);
		check_slot(blob_pointer_addr, 5'd0);
	endtask

	initial begin
		string       tok;
		string       rest;
		int          fd;
		int          r;
		int          cycles;
		byte_t       sw;
		blob_count_t nvb;
		int          pflag;
		logic [5:0]  disp;
		logic [6:0]  cnt;
		mem_addr_t   p;
		mem_word_t   w1;
		mem_word_t   w2;
		pause                 = 1'b0;
		enable                = 1'b0;
		slide_switches        = 8'h00;
		number_of_valid_blobs = '0;
		read_addr             = '0;
		lfsr                  = 32'hc5c7;
		test_count            = 0;
		foreach (ptr_mem[i]) begin
			ptr_mem[i]   = EMPTY_PTR;
			word1_mem[i] = '0;
			word2_mem[i] = '0;
		end
		fd = $fopen("tb_tests.txt", "r");
		if (fd == 0)
			report_failure("could not open tb_tests.txt");
		cycles = 0;
		while (rst !== 1'b0) begin
			if (cycles == 50)
				report_failure("reset was never released");
			@(negedge clk);
			cycles++;
		end
		check_done(done, 1'b0);
		check_display(tracking_display, 6'h00);
		check_mem_addr(address, 18'h0);
		check_slot(blob_pointer_addr, 5'd0);
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				r = $fgets(rest, fd);  // rest of a comment line
			end else if (tok == "test") begin
				r = $fscanf(fd, "%h %d %d %h %d", sw, nvb, pflag, disp, cnt);
				if (r != 5)
					report_failure("bad test header in tb_tests.txt");
				for (int i = 0; i < SLOTS; i++) begin
					r          = $fscanf(fd, "%h", p);
					ptr_mem[i] = p;
				end
				for (int i = 0; i < SLOTS; i++) begin
					w1 = '0;
					w2 = '0;
					if (ptr_mem[i] != EMPTY_PTR)
						r = $fscanf(fd, "%h %h", w1, w2);
					word1_mem[i] = w1;
					word2_mem[i] = w2;
				end
				test_count++;
				run_test(sw, nvb, pflag != 0, disp, cnt);
			end else begin
				report_failure($sformatf("unexpected word %s in tb_tests.txt", tok));
			end
		end
		$fclose(fd);
		if (test_count == 0) begin
			report_failure("tb_tests.txt held no tests");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// File: tb_tests.txt
# test <switches hex> <valid blobs> <pause 0/1> <display hex> <byte count>
# then 20 slot pointers (3ffff is empty) and one "word1 word2" line per non-empty slot
test 01 20 0 19 28
00100 00110 00120 3ffff 3ffff 3ffff 00160 00170 00180 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
00000001 11121314
00000004 21222324
00000005 31323334
00000001 41424344
00000004 51525354
00000005 61626364
test 02 20 0 3f 52
00200 00210 00220 00230 00240 00250 00260 00270 00280 00290
002a0 002b0 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
a0000001 0a0b0c0d
a0000002 1a1b1c1d
a0000003 2a2b2c2d
a0000004 3a3b3c3d
a0000005 4a4b4c4d
a0000006 5a5b5c5d
b0000006 6a6b6c6d
b0000005 7a7b7c7d
b0000004 8a8b8c8d
b0000003 9a9b9c9d
b0000002 aaabacad
b0000001 babbbcbd
test 03 20 1 3f 52
00300 00310 00320 00330 00340 00350 3ffff 3ffff 3ffff 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
e0000006 01020304
e0000005 05060708
e0000004 090a0b0c
e0000003 0d0e0f10
e0000002 11121314
e0000001 15161718
test 01 20 0 33 28
3ffff 00410 00420 3ffff 00440 00450 3ffff 3ffff 3ffff 00490
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
c0000002 d1d2d3d4
c0000001 c1c2c3c4
c0000000 e1e2e3e4
c0000006 f1f2f3f4
c0000005 12345678
test 01 20 1 09 28
00500 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 00570 3ffff 3ffff
3ffff 3ffff 005c0 005d0 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
d0000001 5a5b5c5d
d0000004 6a6b6c6d
d0000005 7a7b7c7d
d0000001 8a8b8c8d
test 02 3 1 07 52
00600 00610 00620 00630 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3ffff
f0000001 21324354
f0000002 65768798
f0000003 a9bacbdc
f0000004 edfe0f10

// File: verilog.f
trk_pkg.sv
blob_if.sv
blob_fetcher.sv
packet_writer.sv
packet_buffer.sv
tracking_output_assembly.sv
tb_clock_gen.sv
tb_tracking_output.sv

// File: Makefile
TOP = tb_tracking_output

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
